//--- Makefile
VERILATOR ?= verilator
TOP       := simd_reduce_tb
FLIST     := flist.f
VFLAGS    := --binary --timing --assert -Wno-fatal
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(filter-out +%,$(shell cat $(FLIST))) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
+incdir+verilog
verilog/simd_pkg.sv
verilog/disassembler.sv
verilog/lane_accumulator.sv
verilog/simd_apb_regs.sv
verilog/simd_reduce_top.sv
verif/simd_reduce_asserts.sv
verif/simd_reduce_tb.sv

//--- verif/simd_reduce_asserts.sv
`timescale 1ns/1ps
`include "simd_defines.svh"

module simd_reduce_asserts (
    input logic                 clk,
    input logic                 rst,
    input logic                 s_tready,
    input simd_pkg::apb_req_t   apb_req,
    input simd_pkg::apb_rsp_t   apb_rsp,
    input logic                 is_header,
    input simd_pkg::lane_beat_t lanes
);

    int   assert_fails = 0;
    logic reg_hit;

    // register map, lane results word aligned
    assign reg_hit = (apb_req.paddr inside {simd_pkg::REG_CTRL, simd_pkg::REG_COUNT,
                                            simd_pkg::REG_HEADER})
                     || ((apb_req.paddr inside {[simd_pkg::REG_LANE0 :
                                                 simd_pkg::REG_LANE0 + 4 * `SIMD_DEGREE - 4]})
                         && (apb_req.paddr[1:0] == 2'b00));

    reset_quiet: assert property (@(posedge clk) rst |=> (!s_tready && !apb_rsp.pslverr))
        else begin
            $error("s_tready or pslverr high right after a reset cycle");
            assert_fails++;
        end

    slverr_in_access: assert property (@(posedge clk) disable iff (rst)
        apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable && !reg_hit))
        else begin
            $error("pslverr high outside an access phase or on a mapped register");
            assert_fails++;
        end

    // a header cycle carries no payload and closes no packet
    no_valid_on_header: assert property (@(posedge clk) disable iff (rst)
        is_header |-> ((lanes.valid == '0) && !lanes.last))
        else begin
            $error("lane valid or last high during a header cycle");
            assert_fails++;
        end

endmodule

bind simd_reduce_top simd_reduce_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .s_tready  (s_tready),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .is_header (is_header),
    .lanes     (lanes)
);

//--- verif/simd_reduce_tb.sv
`timescale 1ns/1ps
`include "simd_defines.svh"

module simd_reduce_tb;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_FULL   = 12;
    localparam int NUM_MASK   = 10;
    localparam int NUM_LEN    = 16;
    localparam int NUM_PKTS   = NUM_FULL + NUM_MASK + NUM_LEN + 1;
    localparam int MAX_WORDS  = 21;  // header plus 20 payload words
    localparam int MAX_BEATS  = (MAX_WORDS + `SIMD_DEGREE - 1) / `SIMD_DEGREE;
    localparam int PKT_CYCLES = 4 * MAX_BEATS + 60;  // beats, idle gap and APB readback
    localparam int TIMEOUT_NS = (NUM_PKTS * PKT_CYCLES + 200) * CLK_PERIOD;

    logic                 clk;
    logic                 rst;
    simd_pkg::axis_beat_t s_beat;
    logic                 s_tready;
    simd_pkg::apb_req_t   apb_req;
    simd_pkg::apb_rsp_t   apb_rsp;

    integer      seed;
    logic [31:0] rnd;
    logic [31:0] pkt_words [MAX_WORDS];
    int          pkt_len;
    logic [31:0] model_res [`SIMD_DEGREE];
    logic [31:0] model_count;
    logic [31:0] model_header;

    simd_reduce_top uut (
        .clk      (clk),
        .rst      (rst),
        .s_beat   (s_beat),
        .s_tready (s_tready),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic apb_access(input logic write, input logic [`APB_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #2;  // access phase, well before the next rising edge
        check_value("pready", {31'd0, apb_rsp.pready}, 32'd1);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, addr, data, rd, err);
        check_value("pslverr", {31'd0, err}, 32'd0);
    endtask

    task automatic read_check(input string name, input logic [`APB_ADDR_W-1:0] addr,
                              input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b0, addr, 32'd0, rd, err);
        check_value("pslverr", {31'd0, err}, 32'd0);
        check_value(name, rd, exp);
    endtask

    task automatic build_packet(input int n_payload);
        pkt_len = n_payload + 1;
        for (int w = 0; w < pkt_len; w++) begin
            rnd = $random(seed);
            pkt_words[w] = rnd;  // word 0 is the header
        end
    endtask

    task automatic drive_packet();
        int nbeats;
        int w;
        nbeats = (pkt_len + `SIMD_DEGREE - 1) / `SIMD_DEGREE;
        for (int b = 0; b < nbeats; b++) begin
            @(negedge clk);
            s_beat = '0;
            for (int j = 0; j < `SIMD_DEGREE; j++) begin
                w = b * `SIMD_DEGREE + j;
                if (w < pkt_len) begin
                    s_beat.tdata[32*j +: 32] = pkt_words[w];
                    s_beat.tkeep[4*j +: 4]   = 4'hf;
                end
            end
            s_beat.tvalid = 1'b1;
            s_beat.tlast  = (b == nbeats - 1);
        end
        @(negedge clk);
        s_beat = '0;  // idle gap
    endtask

    // payload word k lands in lane k mod SIMD_DEGREE
    task automatic apply_model(input logic [`SIMD_DEGREE-1:0] mask);
        logic [31:0] sums [`SIMD_DEGREE];
        for (int i = 0; i < `SIMD_DEGREE; i++) begin
            sums[i] = '0;
        end
        if (mask != '0) begin
            for (int k = 0; k < pkt_len - 1; k++) begin
                sums[k % `SIMD_DEGREE] = sums[k % `SIMD_DEGREE] + pkt_words[k + 1];
            end
            for (int i = 0; i < `SIMD_DEGREE; i++) begin
                if (mask[i]) begin
                    model_res[i] = sums[i];
                end
            end
            model_count  = model_count + 32'd1;
            model_header = pkt_words[0];
        end
    endtask

    task automatic wait_for_count(input logic [31:0] target);
        logic [31:0] cnt;
        logic        err;
        int          polls;
        polls = 0;
        apb_access(1'b0, simd_pkg::REG_COUNT, 32'd0, cnt, err);
        while (cnt != target && polls < 50) begin
            polls++;
            apb_access(1'b0, simd_pkg::REG_COUNT, 32'd0, cnt, err);
        end
        if (cnt != target) begin
            $display("** Error at %0d ns: packet count never reached %0d", $time, target);
            $display("Simulation FAILED");
            $fatal(1, "packet count timeout");
        end
    endtask

    task automatic check_state();
        logic [`APB_ADDR_W-1:0] addr;
        read_check("COUNT", simd_pkg::REG_COUNT, model_count);
        read_check("HEADER", simd_pkg::REG_HEADER, model_header);
        addr = simd_pkg::REG_LANE0;
        for (int i = 0; i < `SIMD_DEGREE; i++) begin
            read_check($sformatf("lane %0d result", i), addr, model_res[i]);
            addr = addr + 8'd4;
        end
    endtask

    task automatic run_packet(input int n_payload, input logic [`SIMD_DEGREE-1:0] mask);
        apb_write(simd_pkg::REG_CTRL, {24'd0, mask, 3'd0, 1'b1});
        build_packet(n_payload);
        drive_packet();
        apply_model(mask);
        if (mask != '0) begin
            wait_for_count(model_count);
        end
        check_state();
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("** Error at %0d ns: watchdog expired before the test finished", $time);
        $display("Simulation FAILED");
        $fatal(1, "watchdog timeout");
    end

    always @(negedge clk) begin
        if (uut.u_asserts.assert_fails != 0) begin
            $display("** Error at %0d ns: a DUT assertion failed", $time);
            $display("Simulation FAILED");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        logic [31:0]             rd;
        logic                    err;
        logic [`SIMD_DEGREE-1:0] mask;
        int                      n_payload;
        seed         = 32'hd38062e1;
        clk          = 1'b0;
        rst          = 1'b1;
        s_beat       = '0;
        apb_req      = '0;
        model_count  = '0;
        model_header = '0;
        for (int i = 0; i < `SIMD_DEGREE; i++) begin
            model_res[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #2;
        check_value("s_tready", {31'd0, s_tready}, 32'd0);
        read_check("CTRL", simd_pkg::REG_CTRL, 32'd0);
        check_state();

        for (int n = 0; n < NUM_FULL; n++) begin
            rnd = $random(seed);
            run_packet(4 + rnd % 17, '1);
        end

        for (int n = 0; n < NUM_MASK; n++) begin
            rnd  = $random(seed);
            mask = rnd[`SIMD_DEGREE-1:0];
            if (mask == '0) begin
                mask = 'd1;
            end
            rnd = $random(seed);
            run_packet(4 + rnd % 17, mask);
        end

        rnd = $random(seed);
        run_packet(4 + rnd % 17, '0);  // dropped, nothing may change

        rnd = $random(seed);
        apb_write(simd_pkg::REG_CTRL, rnd);
        check_value("s_tready", {31'd0, s_tready}, {31'd0, rnd[0]});
        read_check("CTRL", simd_pkg::REG_CTRL, rnd & 32'h0000_00f1);
        apb_access(1'b0, 8'h0c, 32'd0, rd, err);
        check_value("pslverr", {31'd0, err}, 32'd1);
        apb_access(1'b0, 8'h20, 32'd0, rd, err);
        check_value("pslverr", {31'd0, err}, 32'd1);

        // every payload length residue, so last lands in both positions
        for (int n = 0; n < NUM_LEN; n++) begin
            rnd       = $random(seed);
            n_payload = 4 + (n % 4) + 4 * int'(rnd % 4);
            run_packet(n_payload, '1);
        end

        if (uut.u_asserts.assert_fails == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("** Error at %0d ns: %0d assertion failures", $time,
                     uut.u_asserts.assert_fails);
            $display("Simulation FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

//--- verilog/disassembler.sv
`timescale 1ns/1ps
`include "simd_defines.svh"

module disassembler (
    input  logic                    clk,
    input  logic                    rst,
    input  simd_pkg::axis_beat_t    beat_in,
    input  logic                    tready,
    input  logic [`SIMD_DEGREE-1:0] lanes_off,
    output logic                    is_header,
    output simd_pkg::lane_beat_t    lanes
);

    localparam int KEEP_W = `PHIT_SIZE / 8;
    localparam int HDR_W  = `HEADER_BYTES * 8;
    localparam int REST_B = KEEP_W - `HEADER_BYTES;  // bytes held over to the next beat
    localparam int REST_W = REST_B * 8;

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        PAYLOAD
    } state_t;

    state_t state;
    state_t state_next;

    logic [REST_W-1:0] data_d;
    logic [REST_B-1:0] keep_d;
    logic              last_d;
    logic              valid_d;

    logic                     accept;
    logic                     start;
    logic                     load;
    logic                     upper_kept;
    logic [HDR_W-1:0]         data_lo;
    logic [`HEADER_BYTES-1:0] keep_lo;
    logic [KEEP_W-1:0]        keep_out;
    logic [`SIMD_DEGREE-1:0]  keep_condensed;
    logic                     last_now;
    logic                     last_late;

    assign accept = beat_in.tvalid && tready;
    // single-beat packets and all-lanes-off packets never open
    assign start = accept && (state == IDLE) && !(&lanes_off) && !beat_in.tlast;
    assign load = start || (accept && (state != IDLE));
    assign upper_kept = |beat_in.tkeep[KEEP_W-1:`HEADER_BYTES];
    assign is_header = start;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = HEADER;
                end
            end
            HEADER, PAYLOAD: begin
                if (accept) begin
                    state_next = beat_in.tlast ? IDLE : PAYLOAD;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            keep_d  <= '0;
            last_d  <= 1'b0;
            valid_d <= 1'b0;
        end else begin
            state <= state_next;
            if (load) begin
                keep_d  <= beat_in.tkeep[KEEP_W-1:`HEADER_BYTES];
                last_d  <= beat_in.tlast;
                valid_d <= 1'b1;
            end else if (state == IDLE) begin  // residual shown once, then dropped
                keep_d  <= '0;
                last_d  <= 1'b0;
                valid_d <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_d <= beat_in.tdata[`PHIT_SIZE-1:HDR_W];
        end
    end

    // low bytes of the current beat sit on top of the held upper part
    assign data_lo  = accept ? beat_in.tdata[HDR_W-1:0] : '0;
    assign keep_lo  = accept ? beat_in.tkeep[`HEADER_BYTES-1:0] : '0;
    assign keep_out = {keep_lo, keep_d};

    for (genvar i = 0; i < `SIMD_DEGREE; i++) begin : g_cond
        assign keep_condensed[i] = &keep_out[4*i +: 4];
    end

    assign last_now  = accept && (state != IDLE) && beat_in.tlast && !upper_kept;
    assign last_late = valid_d && last_d && (|keep_d);  // leftover bytes after tlast

    always_comb begin
        lanes.data  = {data_lo, data_d};
        lanes.valid = (valid_d && !is_header) ? keep_condensed : '0;
        lanes.last  = last_now || last_late;
    end

endmodule

//--- verilog/lane_accumulator.sv
`timescale 1ns/1ps
`include "simd_defines.svh"

module lane_accumulator (
    input  logic               clk,
    input  logic               rst,
    input  logic               enable,
    input  logic [`LANE_W-1:0] word,
    input  logic               word_valid,
    input  logic               last,
    output logic [`LANE_W-1:0] result
);

    logic [`LANE_W-1:0] sum;
    logic [`LANE_W-1:0] addend;
    logic [`LANE_W-1:0] sum_next;

    assign addend   = (enable && word_valid) ? word : '0;
    assign sum_next = sum + addend;  // wraps at LANE_W bits

    always_ff @(posedge clk) begin
        if (rst) begin
            sum    <= '0;
            result <= '0;
        end else if (last) begin
            sum <= '0;
            if (enable) begin
                result <= sum_next;  // includes the final word
            end
        end else begin
            sum <= sum_next;
        end
    end

endmodule

//--- verilog/simd_apb_regs.sv
`timescale 1ns/1ps
`include "simd_defines.svh"

module simd_apb_regs (
    input  logic                                   clk,
    input  logic                                   rst,
    input  simd_pkg::apb_req_t                     apb_req,
    output simd_pkg::apb_rsp_t                     apb_rsp,
    input  logic                                   is_header,
    input  logic [`LANE_W-1:0]                     header_word,
    input  logic                                   pkt_done,
    input  logic [`SIMD_DEGREE-1:0][`LANE_W-1:0]   lane_results,
    output logic                                   stream_en,
    output logic [`SIMD_DEGREE-1:0]                lane_en
);

    localparam int IDX_W = $clog2(`SIMD_DEGREE);
    localparam logic [`APB_ADDR_W-1:0] LANE_SPAN = 4 * `SIMD_DEGREE;

    logic                   access;
    logic                   wr_ctrl;
    logic [`APB_ADDR_W-1:0] lane_off;
    logic [IDX_W-1:0]       lane_idx;
    logic                   lane_hit;
    logic                   mapped;
    logic [31:0]            rdata;
    logic [31:0]            pkt_count;
    logic [`LANE_W-1:0]     header_q;

    assign access  = apb_req.psel && apb_req.penable;
    assign wr_ctrl = access && apb_req.pwrite && (apb_req.paddr == simd_pkg::REG_CTRL);

    always_ff @(posedge clk) begin
        if (rst) begin
            stream_en <= 1'b0;
            lane_en   <= '0;
        end else if (wr_ctrl) begin
            stream_en <= apb_req.pwdata[0];
            lane_en   <= apb_req.pwdata[4 +: `SIMD_DEGREE];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_count <= '0;
            header_q  <= '0;
        end else begin
            if (pkt_done) begin
                pkt_count <= pkt_count + 32'd1;
            end
            if (is_header) begin
                header_q <= header_word;  // readable next cycle
            end
        end
    end

    // lane result window, word aligned
    assign lane_off = apb_req.paddr - simd_pkg::REG_LANE0;
    assign lane_idx = lane_off[2 +: IDX_W];
    assign lane_hit = (apb_req.paddr >= simd_pkg::REG_LANE0) && (lane_off < LANE_SPAN)
                      && (apb_req.paddr[1:0] == 2'b00);

    always_comb begin
        rdata  = '0;
        mapped = 1'b1;
        if (apb_req.paddr == simd_pkg::REG_CTRL) begin
            rdata[0]                  = stream_en;
            rdata[4 +: `SIMD_DEGREE]  = lane_en;
        end else if (apb_req.paddr == simd_pkg::REG_COUNT) begin
            rdata = pkt_count;
        end else if (apb_req.paddr == simd_pkg::REG_HEADER) begin
            rdata = header_q;
        end else if (lane_hit) begin
            rdata = lane_results[lane_idx];
        end else begin
            mapped = 1'b0;
        end
    end

    always_comb begin
        apb_rsp.prdata  = rdata;
        apb_rsp.pready  = access;  // zero wait states
        apb_rsp.pslverr = access && !mapped;
    end

endmodule

//--- verilog/simd_defines.svh
`ifndef SIMD_DEFINES_SVH
`define SIMD_DEFINES_SVH

// stream width in bits
`define PHIT_SIZE 128
// header length in bytes
`define HEADER_BYTES 4
`define SIMD_DEGREE (`PHIT_SIZE / 32)
`define LANE_W 32
`define APB_ADDR_W 8

`endif

//--- verilog/simd_pkg.sv
`include "simd_defines.svh"

package simd_pkg;

    typedef struct packed {
        logic [`PHIT_SIZE-1:0]   tdata;
        logic [`PHIT_SIZE/8-1:0] tkeep;
        logic                    tlast;
        logic                    tvalid;
    } axis_beat_t;

    // aligned payload after header removal
    typedef struct packed {
        logic [`PHIT_SIZE-1:0]   data;
        logic [`SIMD_DEGREE-1:0] valid;
        logic                    last;
    } lane_beat_t;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        logic [31:0]            pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    localparam logic [`APB_ADDR_W-1:0] REG_CTRL   = 'h00;
    localparam logic [`APB_ADDR_W-1:0] REG_COUNT  = 'h04;
    localparam logic [`APB_ADDR_W-1:0] REG_HEADER = 'h08;
    localparam logic [`APB_ADDR_W-1:0] REG_LANE0  = 'h10;  // lane i at +4*i

endpackage

//--- verilog/simd_reduce_top.sv
`timescale 1ns/1ps
`include "simd_defines.svh"

module simd_reduce_top (
    input  logic                 clk,
    input  logic                 rst,
    input  simd_pkg::axis_beat_t s_beat,
    output logic                 s_tready,
    input  simd_pkg::apb_req_t   apb_req,
    output simd_pkg::apb_rsp_t   apb_rsp
);

    simd_pkg::lane_beat_t                 lanes;
    logic                                 is_header;
    logic                                 stream_en;
    logic [`SIMD_DEGREE-1:0]              lane_en;
    logic [`SIMD_DEGREE-1:0][`LANE_W-1:0] lane_results;

    assign s_tready = stream_en;

    disassembler u_disasm (
        .clk       (clk),
        .rst       (rst),
        .beat_in   (s_beat),
        .tready    (s_tready),
        .lanes_off (~lane_en),
        .is_header (is_header),
        .lanes     (lanes)
    );

    for (genvar i = 0; i < `SIMD_DEGREE; i++) begin : g_lane
        lane_accumulator u_acc (
            .clk        (clk),
            .rst        (rst),
            .enable     (lane_en[i]),
            .word       (lanes.data[i*`LANE_W +: `LANE_W]),
            .word_valid (lanes.valid[i]),
            .last       (lanes.last),
            .result     (lane_results[i])
        );
    end

    simd_apb_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .is_header    (is_header),
        .header_word  (s_beat.tdata[`LANE_W-1:0]),  // header sits in the low word
        .pkt_done     (lanes.last),
        .lane_results (lane_results),
        .stream_en    (stream_en),
        .lane_en      (lane_en)
    );

endmodule
